// File: tpu_acc_pkg.sv
`default_nettype none

package tpu_acc_pkg;

    // number of array lanes, also the wavefront width
    localparam int MUL_SIZE = 8;

    // signed partial sum from one array lane
    localparam int PSUM_W = 16;

    // signed accumulator entry, adds wrap
    localparam int ACC_W = 24;

    // rows held by each lane memory
    localparam int ACC_DEPTH = 64;
    localparam int ACC_AW = $clog2(ACC_DEPTH);

    // row count, one bit wider so a full 64 fits
    localparam int ROWS_W = ACC_AW + 1;

    // control counter covers rows plus the drain of the wavefront
    localparam int CNT_W = $clog2(ACC_DEPTH + MUL_SIZE + 1);

    // last fill count before the first write step
    // needs MUL_SIZE of at least 3
    localparam int FILL_LAST = MUL_SIZE - 3;

    // command opcodes
    typedef enum logic [1:0] {
        // ignored, no error
        OP_NOP      = 2'b00,
        // tile overwrites rows
        OP_TILE_SET = 2'b01,
        // tile adds into rows
        OP_TILE_ADD = 2'b10,
        // rows streamed back out
        OP_READ     = 2'b11
    } acc_op_e;

endpackage

`default_nettype wire

// File: acc_cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module acc_cmd_decode (
    input  wire                                 clk_i,
    input  wire                                 reset_i,
    input  wire                                 cmd_valid_i,
    input  wire tpu_acc_pkg::acc_op_e           cmd_op_i,
    input  wire  [tpu_acc_pkg::ACC_AW-1:0]      cmd_base_i,
    input  wire  [tpu_acc_pkg::ROWS_W-1:0]      cmd_rows_i,
    input  wire                                 tile_done_i,
    input  wire                                 rd_done_i,
    output logic                                tile_start_o,
    output logic                                tile_add_o,
    output logic [tpu_acc_pkg::ACC_AW-1:0]      tile_base_o,
    output logic [tpu_acc_pkg::ROWS_W-1:0]      tile_rows_o,
    output logic                                rd_start_o,
    output logic [tpu_acc_pkg::ACC_AW-1:0]      rd_base_o,
    output logic [tpu_acc_pkg::ROWS_W-1:0]      rd_rows_o,
    output logic                                busy_o,
    output logic                                cmd_err_o
);

    logic                              busy_q;
    logic [tpu_acc_pkg::ROWS_W:0]      span;
    logic                              is_op;
    logic                              range_ok;
    logic                              accept;
    logic                              is_tile;
    logic [tpu_acc_pkg::ACC_AW-1:0]    base_q;
    logic [tpu_acc_pkg::ROWS_W-1:0]    rows_q;

    // busy drops together with the tile done pulse
    // a read clears it one cycle after its last row
    assign busy_o = busy_q && !tile_done_i;

    always_comb begin
        // one extra bit so base plus rows cannot wrap
        span = (tpu_acc_pkg::ROWS_W + 1)'(cmd_base_i)
             + (tpu_acc_pkg::ROWS_W + 1)'(cmd_rows_i);
        range_ok = (cmd_rows_i != '0)
                && (span <= (tpu_acc_pkg::ROWS_W + 1)'(tpu_acc_pkg::ACC_DEPTH));
        // nop never counts as a command
        is_op   = cmd_valid_i && (cmd_op_i != tpu_acc_pkg::OP_NOP);
        accept  = is_op && !busy_o && range_ok;
        is_tile = (cmd_op_i == tpu_acc_pkg::OP_TILE_SET)
               || (cmd_op_i == tpu_acc_pkg::OP_TILE_ADD);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            tile_start_o <= 1'b0;
            rd_start_o   <= 1'b0;
            cmd_err_o    <= 1'b0;
        end else begin
            tile_start_o <= accept && is_tile;
            rd_start_o   <= accept && (cmd_op_i == tpu_acc_pkg::OP_READ);
            // busy, zero rows or out of range
            cmd_err_o    <= is_op && !accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (tile_done_i || rd_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // held for the whole operation, a reject leaves them alone
    always_ff @(posedge clk_i) begin
        if (accept) begin
            base_q     <= cmd_base_i;
            rows_q     <= cmd_rows_i;
            tile_add_o <= (cmd_op_i == tpu_acc_pkg::OP_TILE_ADD);
        end
    end

    // tile and read share the same registered range
    assign tile_base_o = base_q;
    assign tile_rows_o = rows_q;
    assign rd_base_o   = base_q;
    assign rd_rows_o   = rows_q;

endmodule

`default_nettype wire

// File: accumulator_control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module accumulator_control_unit (
    input  wire                                 clk_i,
    input  wire                                 reset_i,
    input  wire                                 tile_start_i,
    input  wire                                 tile_add_i,
    input  wire  [tpu_acc_pkg::ACC_AW-1:0]      tile_base_i,
    input  wire  [tpu_acc_pkg::ROWS_W-1:0]      tile_rows_i,
    output logic [tpu_acc_pkg::MUL_SIZE-1:0]    wr_mask_o,
    output logic [tpu_acc_pkg::ACC_AW-1:0]      wr_row_o,
    output logic                                wr_add_o,
    output logic                                done_o
);

    typedef enum logic [2:0] {
        STALL,
        NO_OUTPUT,
        PARTIAL_OUTPUT,
        FULL_OUTPUT,
        REVERSE_PARTIAL
    } acc_state_e;

    acc_state_e                          state_q;
    acc_state_e                          out_state_nxt;
    logic [tpu_acc_pkg::CNT_W-1:0]       cnt_q;
    logic [tpu_acc_pkg::CNT_W-1:0]       step_nxt;
    logic [tpu_acc_pkg::CNT_W-1:0]       rows_ext;
    logic [tpu_acc_pkg::CNT_W-1:0]       row_sum;
    logic [tpu_acc_pkg::ACC_AW-1:0]      base_q;
    logic [tpu_acc_pkg::ROWS_W-1:0]      rows_q;
    logic [tpu_acc_pkg::MUL_SIZE-1:0]    lo_ok;
    logic [tpu_acc_pkg::MUL_SIZE-1:0]    hi_ok;
    logic [tpu_acc_pkg::MUL_SIZE-1:0]    mask_d;
    logic                                last_step;

    always_comb begin
        rows_ext = tpu_acc_pkg::CNT_W'(rows_q);
        step_nxt = cnt_q + 1'b1;
        // row of lane 0, wraps mod depth so lane k can subtract k
        row_sum  = tpu_acc_pkg::CNT_W'(base_q) + cnt_q;

        // lane k holds row s-k, valid for 0 <= s-k < rows
        for (int k = 0; k < tpu_acc_pkg::MUL_SIZE; k++) begin
            lo_ok[k] = (cnt_q >= tpu_acc_pkg::CNT_W'(k));
            hi_ok[k] = ((cnt_q - tpu_acc_pkg::CNT_W'(k)) < rows_ext);
        end

        case (state_q)
            // rising edge of the wavefront
            PARTIAL_OUTPUT:  mask_d = lo_ok;
            FULL_OUTPUT:     mask_d = '1;
            // lane 0 done, mask falls from the low side
            REVERSE_PARTIAL: mask_d = lo_ok & hi_ok;
            default:         mask_d = '0;
        endcase

        // phase for the following step
        if (step_nxt >= rows_ext) begin
            out_state_nxt = REVERSE_PARTIAL;
        end else if (step_nxt >= tpu_acc_pkg::CNT_W'(tpu_acc_pkg::MUL_SIZE - 1)) begin
            out_state_nxt = FULL_OUTPUT;
        end else begin
            out_state_nxt = PARTIAL_OUTPUT;
        end

        // one step past the last lane's last row, mask is zero here
        last_step = (cnt_q == rows_ext + tpu_acc_pkg::CNT_W'(tpu_acc_pkg::MUL_SIZE - 1));
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= STALL;
            cnt_q     <= '0;
            wr_mask_o <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                STALL: begin
                    wr_mask_o <= '0;
                    if (tile_start_i) begin
                        state_q <= NO_OUTPUT;
                        cnt_q   <= '0;
                    end
                end
                NO_OUTPUT: begin
                    // wait for the array to fill
                    wr_mask_o <= '0;
                    if (cnt_q == tpu_acc_pkg::CNT_W'(tpu_acc_pkg::FILL_LAST)) begin
                        state_q <= PARTIAL_OUTPUT;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= step_nxt;
                    end
                end
                default: begin
                    // one write step per cycle
                    wr_mask_o <= mask_d;
                    cnt_q     <= step_nxt;
                    if (last_step) begin
                        done_o  <= 1'b1;
                        state_q <= STALL;
                    end else begin
                        state_q <= out_state_nxt;
                    end
                end
            endcase
        end
    end

    // tile range captured at start, row and mode follow the mask
    always_ff @(posedge clk_i) begin
        if ((state_q == STALL) && tile_start_i) begin
            base_q <= tile_base_i;
            rows_q <= tile_rows_i;
        end
        wr_row_o <= row_sum[tpu_acc_pkg::ACC_AW-1:0];
        wr_add_o <= tile_add_i;
    end

endmodule

`default_nettype wire

// File: acc_bank.sv
`timescale 1ns/1ns
`default_nettype none

module acc_bank (
    input  wire                                               clk_i,
    input  wire  [tpu_acc_pkg::MUL_SIZE-1:0]                  wr_mask_i,
    input  wire  [tpu_acc_pkg::ACC_AW-1:0]                    wr_row_i,
    input  wire                                               wr_add_i,
    input  wire  [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::PSUM_W-1:0] psum_i,
    input  wire                                               rd_en_i,
    input  wire  [tpu_acc_pkg::ACC_AW-1:0]                    rd_addr_i,
    output logic [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::ACC_W-1:0]  rd_data_o
);

    // one memory per lane
    for (genvar k = 0; k < tpu_acc_pkg::MUL_SIZE; k++) begin : g_lane
        logic [tpu_acc_pkg::ACC_W-1:0]   mem_q [tpu_acc_pkg::ACC_DEPTH];
        logic [tpu_acc_pkg::ACC_AW-1:0]  wr_addr;
        logic [tpu_acc_pkg::PSUM_W-1:0]  psum;
        logic [tpu_acc_pkg::ACC_W-1:0]   psum_ext;
        logic [tpu_acc_pkg::ACC_W-1:0]   rd_q;

        always_comb begin
            // lane k lags lane 0 by k rows, undo the skew
            wr_addr  = wr_row_i - tpu_acc_pkg::ACC_AW'(k);
            psum     = psum_i[k*tpu_acc_pkg::PSUM_W +: tpu_acc_pkg::PSUM_W];
            // sign extend to entry width
            psum_ext = {{(tpu_acc_pkg::ACC_W - tpu_acc_pkg::PSUM_W){psum[tpu_acc_pkg::PSUM_W-1]}},
                        psum};
        end

        always_ff @(posedge clk_i) begin
            if (wr_mask_i[k]) begin
                // two's complement add, wraps at entry width
                if (wr_add_i) begin
                    mem_q[wr_addr] <= mem_q[wr_addr] + psum_ext;
                end else begin
                    mem_q[wr_addr] <= psum_ext;
                end
            end
            // registered read, old data on a same-row write
            if (rd_en_i) begin
                rd_q <= mem_q[rd_addr_i];
            end
        end

        assign rd_data_o[k*tpu_acc_pkg::ACC_W +: tpu_acc_pkg::ACC_W] = rd_q;
    end

endmodule

`default_nettype wire

// File: acc_readout.sv
`timescale 1ns/1ns
`default_nettype none

module acc_readout (
    input  wire                                                  clk_i,
    input  wire                                                  reset_i,
    input  wire                                                  rd_start_i,
    input  wire  [tpu_acc_pkg::ACC_AW-1:0]                       rd_base_i,
    input  wire  [tpu_acc_pkg::ROWS_W-1:0]                       rd_rows_i,
    input  wire  [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::ACC_W-1:0]  rd_data_i,
    output logic                                                 rd_en_o,
    output logic [tpu_acc_pkg::ACC_AW-1:0]                       rd_addr_o,
    output logic                                                 rd_done_o,
    output logic                                                 res_valid_o,
    output logic [tpu_acc_pkg::ACC_AW-1:0]                       res_row_o,
    output logic [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::ACC_W-1:0]  res_data_o
);

    // reads still to issue after the current one
    logic [tpu_acc_pkg::ROWS_W-1:0]  left_q;
    logic                            last;

    assign last = rd_en_o && (left_q == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_en_o     <= 1'b0;
            left_q      <= '0;
            res_valid_o <= 1'b0;
            rd_done_o   <= 1'b0;
        end else begin
            // valid lines up with the registered memory read
            res_valid_o <= rd_en_o;
            rd_done_o   <= last;
            if (rd_start_i) begin
                rd_en_o <= 1'b1;
                left_q  <= rd_rows_i - tpu_acc_pkg::ROWS_W'(1);
            end else if (rd_en_o) begin
                if (last) begin
                    rd_en_o <= 1'b0;
                end else begin
                    left_q <= left_q - tpu_acc_pkg::ROWS_W'(1);
                end
            end
        end
    end

    // address walk, row number delayed with the data
    always_ff @(posedge clk_i) begin
        res_row_o <= rd_addr_o;
        if (rd_start_i) begin
            rd_addr_o <= rd_base_i;
        end else if (rd_en_o && !last) begin
            rd_addr_o <= rd_addr_o + tpu_acc_pkg::ACC_AW'(1);
        end
    end

    // bank output is already registered
    assign res_data_o = rd_data_i;

endmodule

`default_nettype wire

// File: tpu_acc_top.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_acc_top (
    input  wire                                                  clk_i,
    input  wire                                                  reset_i,
    input  wire                                                  cmd_valid_i,
    input  wire tpu_acc_pkg::acc_op_e                            cmd_op_i,
    input  wire  [tpu_acc_pkg::ACC_AW-1:0]                       cmd_base_i,
    input  wire  [tpu_acc_pkg::ROWS_W-1:0]                       cmd_rows_i,
    input  wire  [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::PSUM_W-1:0] psum_i,
    output logic                                                 busy_o,
    output logic                                                 cmd_err_o,
    output logic                                                 done_o,
    output logic                                                 res_valid_o,
    output logic [tpu_acc_pkg::ACC_AW-1:0]                       res_row_o,
    output logic [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::ACC_W-1:0]  res_data_o
);

    // decode to control
    logic                                                tile_start;
    logic                                                tile_add;
    logic [tpu_acc_pkg::ACC_AW-1:0]                      tile_base;
    logic [tpu_acc_pkg::ROWS_W-1:0]                      tile_rows;
    // control to bank and decode
    logic [tpu_acc_pkg::MUL_SIZE-1:0]                    wr_mask;
    logic [tpu_acc_pkg::ACC_AW-1:0]                      wr_row;
    logic                                                wr_add;
    logic                                                done;
    // decode and readout
    logic                                                rd_start;
    logic [tpu_acc_pkg::ACC_AW-1:0]                      rd_base;
    logic [tpu_acc_pkg::ROWS_W-1:0]                      rd_rows;
    logic                                                rd_done;
    // readout and bank
    logic                                                rd_en;
    logic [tpu_acc_pkg::ACC_AW-1:0]                      rd_addr;
    logic [tpu_acc_pkg::MUL_SIZE*tpu_acc_pkg::ACC_W-1:0] rd_data;

    assign done_o = done;

    acc_cmd_decode u_decode (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_base_i   (cmd_base_i),
        .cmd_rows_i   (cmd_rows_i),
        .tile_done_i  (done),
        .rd_done_i    (rd_done),
        .tile_start_o (tile_start),
        .tile_add_o   (tile_add),
        .tile_base_o  (tile_base),
        .tile_rows_o  (tile_rows),
        .rd_start_o   (rd_start),
        .rd_base_o    (rd_base),
        .rd_rows_o    (rd_rows),
        .busy_o       (busy_o),
        .cmd_err_o    (cmd_err_o)
    );

    accumulator_control_unit u_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .tile_start_i (tile_start),
        .tile_add_i   (tile_add),
        .tile_base_i  (tile_base),
        .tile_rows_i  (tile_rows),
        .wr_mask_o    (wr_mask),
        .wr_row_o     (wr_row),
        .wr_add_o     (wr_add),
        .done_o       (done)
    );

    acc_bank u_bank (
        .clk_i     (clk_i),
        .wr_mask_i (wr_mask),
        .wr_row_i  (wr_row),
        .wr_add_i  (wr_add),
        .psum_i    (psum_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    acc_readout u_readout (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_start_i  (rd_start),
        .rd_base_i   (rd_base),
        .rd_rows_i   (rd_rows),
        .rd_data_i   (rd_data),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .rd_done_o   (rd_done),
        .res_valid_o (res_valid_o),
        .res_row_o   (res_row_o),
        .res_data_o  (res_data_o)
    );

endmodule

`default_nettype wire

// File: tpu_acc_assert.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_acc_assert (
    input wire                                 clk_i,
    input wire                                 reset_i,
    input wire                                 busy_i,
    input wire [tpu_acc_pkg::MUL_SIZE-1:0]     wr_mask_i,
    input wire                                 cmd_err_i,
    input wire                                 done_i,
    input wire                                 res_valid_i,
    input wire [tpu_acc_pkg::ACC_AW-1:0]       res_row_i
);

    // count of failed checks
    int fail_cnt = 0;

    logic [tpu_acc_pkg::MUL_SIZE-1:0] low_bit;
    logic [tpu_acc_pkg::MUL_SIZE-1:0] run_end;

    always_comb begin
        // lowest set bit of the mask
        low_bit = wr_mask_i & (~wr_mask_i + 1'b1);
        // a single run carries out of itself completely
        run_end = wr_mask_i + low_bit;
    end

    mask_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        !busy_i |-> (wr_mask_i == '0))
        else begin
            fail_cnt++;
            $error("write mask set while not busy");
        end

    mask_run: assert property (@(posedge clk_i) disable iff (reset_i)
        (run_end & wr_mask_i) == '0)
        else begin
            fail_cnt++;
            $error("write mask is not one contiguous run");
        end

    err_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_err_i |=> !cmd_err_i)
        else begin
            fail_cnt++;
            $error("cmd_err_o longer than one cycle");
        end

    done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done_o longer than one cycle");
        end

    // rows stream in order
    row_step: assert property (@(posedge clk_i) disable iff (reset_i)
        res_valid_i ##1 res_valid_i |-> res_row_i == $past(res_row_i) + 1'b1)
        else begin
            fail_cnt++;
            $error("res_row_o skipped a row");
        end

endmodule

bind tpu_acc_top tpu_acc_assert u_props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .busy_i      (busy_o),
    .wr_mask_i   (wr_mask),
    .cmd_err_i   (cmd_err_o),
    .done_i      (done_o),
    .res_valid_i (res_valid_o),
    .res_row_i   (res_row_o)
);

`default_nettype wire

// File: tb_tpu_acc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tpu_acc;

    localparam int M = tpu_acc_pkg::MUL_SIZE;
    localparam int PW = tpu_acc_pkg::PSUM_W;
    localparam int EW = tpu_acc_pkg::ACC_W;
    localparam int AW = tpu_acc_pkg::ACC_AW;
    localparam int RW = tpu_acc_pkg::ROWS_W;
    localparam int DEPTH = tpu_acc_pkg::ACC_DEPTH;
    localparam logic [31:0] SEED = 32'd94695;

    logic                  clk_i;
    logic                  reset_i;
    logic                  cmd_valid;
    tpu_acc_pkg::acc_op_e  cmd_op;
    logic [AW-1:0]         cmd_base;
    logic [RW-1:0]         cmd_rows;
    logic [M*PW-1:0]       psum;
    logic                  busy;
    logic                  cmd_err;
    logic                  done;
    logic                  res_valid;
    logic [AW-1:0]         res_row;
    logic [M*EW-1:0]       res_data;

    // reference accumulator indexed by row then lane
    logic [EW-1:0]  acc_model [DEPTH][M];
    logic [31:0]    cmd_seed;
    logic [31:0]    psum_seed;
    int             cyc = 0;
    int             cmd_edge;
    // tile the array model is feeding
    logic           tile_on;
    logic           tile_add;
    int             tile_edge;
    int             tile_base;
    int             tile_rows;

    tpu_acc_top UUT (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_op_i    (cmd_op),
        .cmd_base_i  (cmd_base),
        .cmd_rows_i  (cmd_rows),
        .psum_i      (psum),
        .busy_o      (busy),
        .cmd_err_o   (cmd_err),
        .done_o      (done),
        .res_valid_o (res_valid),
        .res_row_o   (res_row),
        .res_data_o  (res_data)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // rising edges so far
    always @(posedge clk_i) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic abort_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // array model drives a fresh value on every lane each cycle
    // lane k row r lands at edge E + M + 1 + r + k
    always @(negedge clk_i) begin : array_model
        int r;
        logic [PW-1:0] v;
        for (int k = 0; k < M; k++) begin
            psum_seed = lcg_step(psum_seed);
            v = psum_seed[31:16];
            psum[k*PW +: PW] = v;
            r = cyc + 1 - tile_edge - (M + 1) - k;
            if (tile_on && r >= 0 && r < tile_rows) begin
                if (tile_add) begin
                    acc_model[tile_base + r][k] = acc_model[tile_base + r][k] + EW'($signed(v));
                end else begin
                    acc_model[tile_base + r][k] = EW'($signed(v));
                end
            end
        end
    end

    // bound protocol checks
    always @(negedge clk_i) begin
        assert (UUT.u_props.fail_cnt == 0) else flag_mismatch("protocol assertion failed");
    end

    task automatic send_cmd(input int op, input int base, input int rows);
        cmd_valid = 1'b1;
        cmd_op    = tpu_acc_pkg::acc_op_e'(op);
        cmd_base  = AW'(base);
        cmd_rows  = RW'(rows);
        cmd_edge  = cyc + 1;
        @(negedge clk_i);
        cmd_valid = 1'b0;
    endtask

    task automatic arm_tile(input logic add, input int base, input int rows);
        tile_add  = add;
        tile_base = base;
        tile_rows = rows;
        tile_edge = cyc + 1;
        tile_on   = 1'b1;
    endtask

    task automatic finish_tile();
        int n;
        int due;
        // cycle after the last lane writes its last row
        due = tile_edge + M + 1 + (tile_rows - 1) + (M - 1);
        n = 0;
        while (done !== 1'b1) begin
            assert (busy === 1'b1 && cmd_err === 1'b0) else flag_mismatch("busy lost in tile");
            @(negedge clk_i);
            n++;
            if (n > 200) abort_timeout("done_o at the end of a tile");
        end
        assert (cyc == due) else flag_mismatch($sformatf("done at %0d, expected %0d", cyc, due));
        assert (busy === 1'b0) else flag_mismatch("busy_o still high with done_o");
        tile_on = 1'b0;
    endtask

    task automatic collect_rows(input int base, input int rows);
        int n;
        logic [M*EW-1:0] want;
        n = 0;
        while (res_valid !== 1'b1) begin
            @(negedge clk_i);
            n++;
            if (n > 10) abort_timeout("the first result row");
        end
        assert (cyc == cmd_edge + 2) else flag_mismatch("first result row at wrong cycle");
        for (int i = 0; i < rows; i++) begin
            for (int k = 0; k < M; k++) begin
                want[k*EW +: EW] = acc_model[base + i][k];
            end
            assert (res_valid === 1'b1 && res_row === AW'(base + i))
                else flag_mismatch($sformatf("row %0d: got row %0d", base + i, res_row));
            assert (res_data === want)
                else flag_mismatch($sformatf("row %0d: data %h, expected %h",
                                              base + i, res_data, want));
            if (i < rows - 1) begin
                @(negedge clk_i);
            end
        end
    endtask

    // one command checked by kind and then back to idle
    task automatic run_cmd(input int op, input int base, input int rows);
        logic legal;
        logic tile;
        legal = (rows > 0) && (base + rows <= DEPTH);
        tile  = (op == tpu_acc_pkg::OP_TILE_SET) || (op == tpu_acc_pkg::OP_TILE_ADD);
        if (legal && tile) begin
            arm_tile(op == tpu_acc_pkg::OP_TILE_ADD, base, rows);
        end
        send_cmd(op, base, rows);
        if (op == tpu_acc_pkg::OP_NOP) begin
            assert (cmd_err === 1'b0 && busy === 1'b0) else flag_mismatch("nop was not ignored");
        end else if (!legal) begin
            assert (cmd_err === 1'b1 && busy === 1'b0)
                else flag_mismatch($sformatf("no reject for base %0d rows %0d", base, rows));
        end else if (tile) begin
            finish_tile();
        end else begin
            collect_rows(base, rows);
        end
        @(negedge clk_i);
        assert (busy === 1'b0 && res_valid === 1'b0 && done === 1'b0 && cmd_err === 1'b0)
            else flag_mismatch("outputs not idle after operation");
    endtask

    initial begin : main
        int op;
        int base;
        int rows;
        cmd_valid = 1'b0;
        cmd_op    = tpu_acc_pkg::OP_NOP;
        cmd_base  = '0;
        cmd_rows  = '0;
        psum      = '0;
        reset_i   = 1'b1;
        tile_on   = 1'b0;
        tile_edge = 0;
        tile_rows = 0;
        tile_base = 0;
        tile_add  = 1'b0;
        cmd_seed  = SEED;
        psum_seed = SEED;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        assert (busy === 1'b0 && res_valid === 1'b0 && done === 1'b0 && cmd_err === 1'b0)
            else flag_mismatch("outputs not low after reset");
        // whole memory known and tile also ends at row 63
        run_cmd(tpu_acc_pkg::OP_TILE_SET, 0, 64);
        run_cmd(tpu_acc_pkg::OP_READ, 0, 64);
        run_cmd(tpu_acc_pkg::OP_TILE_SET, 4, 20);
        run_cmd(tpu_acc_pkg::OP_READ, 0, 30);
        run_cmd(tpu_acc_pkg::OP_TILE_ADD, 4, 20);
        run_cmd(tpu_acc_pkg::OP_READ, 0, 30);
        // short tile without a full phase
        run_cmd(tpu_acc_pkg::OP_TILE_SET, 40, 3);
        run_cmd(tpu_acc_pkg::OP_TILE_ADD, 57, 7);
        run_cmd(tpu_acc_pkg::OP_READ, 32, 32);
        run_cmd(tpu_acc_pkg::OP_READ, 10, 0);
        run_cmd(tpu_acc_pkg::OP_TILE_SET, 60, 5);
        run_cmd(tpu_acc_pkg::OP_TILE_ADD, 0, 0);
        // second command while a tile runs
        arm_tile(1'b1, 8, 12);
        send_cmd(tpu_acc_pkg::OP_TILE_ADD, 8, 12);
        repeat (3) @(negedge clk_i);
        send_cmd(tpu_acc_pkg::OP_TILE_SET, 0, 4);
        assert (cmd_err === 1'b1) else flag_mismatch("command while busy not rejected");
        @(negedge clk_i);
        finish_tile();
        @(negedge clk_i);
        run_cmd(tpu_acc_pkg::OP_READ, 0, 64);
        for (int j = 0; j < 30; j++) begin
            cmd_seed = lcg_step(cmd_seed);
            op   = cmd_seed[31:30];
            base = cmd_seed[29:24];
            rows = cmd_seed[20:16];
            run_cmd(op, base, rows);
        end
        run_cmd(tpu_acc_pkg::OP_READ, 0, 64);
        @(negedge clk_i);
        if (UUT.u_props.fail_cnt == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: build.f
tpu_acc_pkg.sv
acc_cmd_decode.sv
accumulator_control_unit.sv
acc_bank.sv
acc_readout.sv
tpu_acc_top.sv
tpu_acc_assert.sv
tb_tpu_acc.sv

// File: Bender.yml
package:
  name: tpu_acc

sources:
  - tpu_acc_pkg.sv
  - acc_cmd_decode.sv
  - accumulator_control_unit.sv
  - acc_bank.sv
  - acc_readout.sv
  - tpu_acc_top.sv
  - target: test
    files:
      - tpu_acc_assert.sv
      - tb_tpu_acc.sv
